// File: flist.f
hw/upload_pkg.sv
hw/sync_fifo.sv
hw/upload_ingress.sv
hw/frame_packer.sv
hw/upload_arbiter.sv
hw/upload_hub.sv
test/tb_clock_gen.sv
test/upload_hub_sva.sv
test/tb_upload_hub.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the upload hub testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_upload_hub

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_upload_hub -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: test/tb_upload_hub.sv
`timescale 1ns/1ps

module tb_upload_hub import upload_pkg::*; ();

    typedef byte_t byte_q_t [$];
    localparam int WAIT_LIMIT = 4000;

    logic                 clk;
    logic                 rst_n;
    src_in_t              src [NUM_LANES];
    logic [NUM_LANES-1:0] src_ready;
    byte_t                usb_upload_data;
    logic                 usb_upload_valid;
    logic                 usb_upload_ready;

    int          err_count = 0;
    int          checks = 0;
    int          tests = 0;
    bit          random_ready = 1'b0;
    bit          in_frame = 1'b0;
    int unsigned lcg_state = 7947;

    // expected and received, per lane
    byte_t      exp_data [NUM_LANES][$];
    int         exp_len  [NUM_LANES][$];
    byte_t      rx_data  [NUM_LANES][$];
    int         rx_len   [NUM_LANES][$];
    source_id_t rx_src   [$];

    tb_clock_gen #(.PERIOD(40ns), .RESET_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

    upload_hub #(.NUM_LANES(NUM_LANES)) DUT (
        .clk(clk), .rst_n(rst_n), .src(src), .src_ready(src_ready),
        .usb_upload_data(usb_upload_data), .usb_upload_valid(usb_upload_valid),
        .usb_upload_ready(usb_upload_ready)
    );

    bind upload_arbiter upload_hub_sva #(.NUM_LANES(NUM_LANES)) u_sva (
        .clk(clk), .rst_n(rst_n), .lane_out(lane_out), .lane_pop(lane_pop),
        .usb_upload_data(usb_upload_data), .usb_upload_valid(usb_upload_valid),
        .usb_upload_ready(usb_upload_ready)
    );

    // ==============================
    // helpers
    // ==============================

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic byte_q_t make_bytes(int n);
        byte_q_t q;
        for (int i = 0; i < n; i++) begin
            q.push_back(byte_t'(lcg_next()));
        end
        return q;
    endfunction

    task automatic check_byte(byte_t got, byte_t exp, string what);
        checks++;
        if (got !== exp) begin
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_source(source_id_t got, source_id_t exp, string what);
        checks++;
        if (got !== exp) begin
            $display("Fail %0t: %s source %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        checks++;
        if (got != exp) begin
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
            err_count++;
        end
    endtask

    // usb side ready, random or held high
    always @(posedge clk) begin
        int unsigned r;
        if (random_ready) begin
            r = lcg_next();
            usb_upload_ready <= r[3];
        end else begin
            usb_upload_ready <= 1'b1;
        end
    end

    // checksum model: source + length + data
    task automatic take_frame(byte_t f[$]);
        byte_t sum;
        int    lane;
        check_byte(f[0], 8'hAA, "header high");
        check_byte(f[1], 8'h44, "header low");
        sum = f[2] + f[3];
        for (int i = 4; i < f.size() - 1; i++) begin
            sum = sum + f[i];
        end
        check_byte(f[f.size()-1], sum, "checksum");
        rx_src.push_back(f[2]);
        // source codes run 1..4 for lanes 0..3
        lane = int'(f[2]) - 1;
        if (lane < 0 || lane >= NUM_LANES) begin
            $display("Fail %0t: frame carries unknown source code %h", $time, f[2]);
            err_count++;
        end else begin
            rx_len[lane].push_back(int'(f[3]));
            for (int i = 4; i < f.size() - 1; i++) begin
                rx_data[lane].push_back(f[i]);
            end
        end
    endtask

    // frame parser on the usb stream, length byte gives the end
    initial begin : collector
        byte_t fbuf [$];
        int    need;
        need = 0;
        forever begin
            @(negedge clk);
            if (rst_n && usb_upload_valid && usb_upload_ready) begin
                fbuf.push_back(usb_upload_data);
                if (fbuf.size() == 4) begin
                    need = 5 + int'(fbuf[3]);
                end
                if (fbuf.size() >= 5 && fbuf.size() == need) begin
                    take_frame(fbuf);
                    fbuf = {};
                end
            end
            in_frame = (fbuf.size() != 0);
        end
    end

    // ==============================
    // channel driver
    // ==============================

    task automatic wait_ready(int lane);
        int n;
        n = 0;
        @(negedge clk);
        while (!src_ready[lane] && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!src_ready[lane]) begin
            $display("Timeout: lane %0d never became ready", lane);
            err_count++;
        end
    endtask

    task automatic send_burst(int lane, byte_q_t bytes);
        wait_ready(lane);
        @(posedge clk);
        src[lane].active <= 1'b1;
        // ready sampled with valid low, so the strobe lands in a ready cycle
        foreach (bytes[i]) begin
            wait_ready(lane);
            @(posedge clk);
            src[lane].valid <= 1'b1;
            src[lane].data  <= bytes[i];
            @(posedge clk);
            src[lane].valid <= 1'b0;
        end
        src[lane].active <= 1'b0;
    endtask

    // full frames of 16, remainder in the last one
    task automatic plan_burst(int lane, byte_q_t bytes);
        int rem;
        rem = bytes.size();
        foreach (bytes[i]) begin
            exp_data[lane].push_back(bytes[i]);
        end
        while (rem > 0) begin
            exp_len[lane].push_back(rem > 16 ? 16 : rem);
            rem = rem - 16;
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
            if (!in_frame && rx_data[0].size() == exp_data[0].size() &&
                rx_data[1].size() == exp_data[1].size() &&
                rx_data[2].size() == exp_data[2].size() &&
                rx_data[3].size() == exp_data[3].size()) begin
                n = WAIT_LIMIT + 1;
            end
        end
        if (n == WAIT_LIMIT) begin
            $display("Timeout: expected bytes did not all arrive on usb");
            err_count++;
        end
    endtask

    task automatic compare_all();
        for (int l = 0; l < NUM_LANES; l++) begin
            check_count(rx_data[l].size(), exp_data[l].size(), $sformatf("lane %0d bytes", l));
            check_count(rx_len[l].size(), exp_len[l].size(), $sformatf("lane %0d frames", l));
            for (int i = 0; i < exp_data[l].size(); i++) begin
                if (i < rx_data[l].size()) begin
                    check_byte(rx_data[l][i], exp_data[l][i],
                               $sformatf("lane %0d data %0d", l, i));
                end
            end
            for (int i = 0; i < exp_len[l].size(); i++) begin
                if (i < rx_len[l].size()) begin
                    check_count(rx_len[l][i], exp_len[l][i], $sformatf("lane %0d length", l));
                end
            end
            exp_data[l] = {};
            exp_len[l]  = {};
            rx_data[l]  = {};
            rx_len[l]   = {};
        end
    endtask

    task automatic report_test(string name, int errs_before);
        tests++;
        $display("test %s: %s", name, (err_count == errs_before) ? "ok" : "mismatches seen");
    endtask

    // ==============================
    // directed tests
    // ==============================

    task automatic test_single_burst();
        int      e0;
        byte_q_t b;
        e0 = err_count;
        check_count(int'(usb_upload_valid), 0, "usb valid after reset");
        check_count(int'(src_ready), 15, "src_ready after reset");
        b = make_bytes(5);
        plan_burst(2, b);
        send_burst(2, b);
        wait_drained();
        check_count(rx_src.size(), 1, "frames seen");
        if (rx_src.size() > 0) begin
            check_source(rx_src[0], 8'h03, "lane 2 frame");
        end
        rx_src = {};
        compare_all();
        report_test("single_burst", e0);
    endtask

    task automatic test_long_burst();
        int      e0;
        byte_q_t b;
        e0 = err_count;
        b = make_bytes(40);
        plan_burst(0, b);
        send_burst(0, b);
        wait_drained();
        rx_src = {};
        compare_all();
        report_test("long_burst", e0);
    endtask

    // bursts on every lane at once, extra pass under random ready
    task automatic test_multi_lane(string name, bit rnd, int rounds);
        int      e0;
        byte_q_t burst [NUM_LANES][2];
        int      lens [NUM_LANES];
        e0 = err_count;
        lens = '{3, 7, 12, 16};
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int r = 0; r < rounds; r++) begin
                burst[l][r] = make_bytes(rnd ? 1 + int'(lcg_next() % 40) : lens[l]);
                plan_burst(l, burst[l][r]);
            end
        end
        random_ready = rnd;
        for (int l = 0; l < NUM_LANES; l++) begin
            automatic int ln = l;
            fork
                begin
                    for (int r = 0; r < rounds; r++) begin
                        send_burst(ln, burst[ln][r]);
                    end
                end
            join_none
        end
        wait fork;
        wait_drained();
        random_ready = 1'b0;
        if (!rnd) begin
            check_count(rx_src.size(), NUM_LANES, "frames seen");
        end
        rx_src = {};
        compare_all();
        report_test(name, e0);
    endtask

    task automatic test_empty_burst();
        int e0;
        e0 = err_count;
        wait_ready(1);
        @(posedge clk);
        src[1].active <= 1'b1;
        repeat (3) @(posedge clk);
        src[1].active <= 1'b0;
        // quiet window on usb
        repeat (60) begin
            @(negedge clk);
            if (usb_upload_valid) begin
                $display("Error at %0t: empty burst produced usb output", $time);
                err_count++;
            end
        end
        check_count(int'(src_ready), 15, "src_ready after empty burst");
        report_test("empty_burst", e0);
    endtask

    initial begin
        int n;
        for (int l = 0; l < NUM_LANES; l++) begin
            src[l] <= '0;
        end
        usb_upload_ready <= 1'b1;
        n = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("Timeout: reset never released");
            err_count++;
        end
        @(negedge clk);
        test_single_burst();
        test_long_burst();
        test_multi_lane("all_lanes", 1'b0, 1);
        test_multi_lane("backpressure", 1'b1, 2);
        test_empty_burst();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, err_count);
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: test/upload_hub_sva.sv
`timescale 1ns/1ps

module upload_hub_sva import upload_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input logic                 clk,
    input logic                 rst_n,
    input lane_out_t            lane_out [NUM_LANES],
    input logic [NUM_LANES-1:0] lane_pop,
    input byte_t                usb_upload_data,
    input logic                 usb_upload_valid,
    input logic                 usb_upload_ready
);

    // usb head must hold while stalled
    a_usb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (usb_upload_valid && !usb_upload_ready) |=>
        (usb_upload_valid && $stable(usb_upload_data)))
        else $error("usb output moved while ready was low");

    // never two lanes popped together
    a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(lane_pop))
        else $error("more than one lane popped in a cycle");

    // pop only a beat that is really there
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_pop
        a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
            lane_pop[i] |-> lane_out[i].valid)
            else $error("lane %0d popped without a valid beat", i);
    end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter time PERIOD       = 40ns,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held low for a few edges
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: hw/upload_hub.sv
`timescale 1ns/1ps

module upload_hub import upload_pkg::*; #(
    parameter int NUM_LANES = upload_pkg::NUM_LANES
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  src_in_t              src [NUM_LANES],
    output logic [NUM_LANES-1:0] src_ready,
    output byte_t                usb_upload_data,
    output logic                 usb_upload_valid,
    input  logic                 usb_upload_ready
);

    // ==============================
    // internal links
    // ==============================

    lane_in_t             lane_in  [NUM_LANES];
    lane_out_t            lane_out [NUM_LANES];
    logic [NUM_LANES-1:0] lane_pop;

    // one cycle register stage on every channel
    upload_ingress #(
        .NUM_LANES (NUM_LANES)
    ) u_ingress (
        .clk     (clk),
        .rst_n   (rst_n),
        .src     (src),
        .lane_in (lane_in)
    );

    // one framer per channel, source code by lane index
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        frame_packer #(
            .MAX_FRAME_DATA (MAX_FRAME_DATA),
            .SOURCE_ID      (lane_source_ids[g])
        ) u_packer (
            .clk      (clk),
            .rst_n    (rst_n),
            .lane_in  (lane_in[g]),
            .in_ready (src_ready[g]),
            .lane_out (lane_out[g]),
            .lane_pop (lane_pop[g])
        );
    end

    // frame-granular merge toward usb
    upload_arbiter #(
        .NUM_LANES      (NUM_LANES),
        .OUT_FIFO_DEPTH (OUT_FIFO_DEPTH)
    ) u_arbiter (
        .clk              (clk),
        .rst_n            (rst_n),
        .lane_out         (lane_out),
        .lane_pop         (lane_pop),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid),
        .usb_upload_ready (usb_upload_ready)
    );

endmodule

// File: hw/upload_arbiter.sv
`timescale 1ns/1ps

module upload_arbiter import upload_pkg::*; #(
    parameter int NUM_LANES      = 4,
    parameter int OUT_FIFO_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lane_out_t            lane_out [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_pop,
    output byte_t                usb_upload_data,
    output logic                 usb_upload_valid,
    input  logic                 usb_upload_ready
);

    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    // grant_idx doubles as the round-robin pointer
    logic             locked;
    logic [IDX_W-1:0] grant_idx;
    logic             pick_found;
    logic [IDX_W-1:0] pick_idx;
    lane_out_t        sel_out;
    logic             beat_move;
    logic             out_full;
    logic             out_empty;
    logic             usb_pop;
    upload_beat_t     out_head;

    // ==============================
    // round-robin pick
    // ==============================

    // scan downward so the nearest lane after the pointer wins
    // the pointer's own lane comes last
    always_comb begin
        int cand;
        pick_found = 1'b0;
        pick_idx   = grant_idx;
        for (int k = NUM_LANES; k >= 1; k--) begin
            cand = (int'(grant_idx) + k) % NUM_LANES;
            if (lane_out[cand].frame_ready) begin
                pick_found = 1'b1;
                pick_idx   = IDX_W'(cand);
            end
        end
    end

    // grant held until the checksum beat goes through
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked    <= 1'b0;
            grant_idx <= '0;
        end else if (!locked) begin
            if (pick_found) begin
                locked    <= 1'b1;
                grant_idx <= pick_idx;
            end
        end else if (beat_move && sel_out.beat.last) begin
            locked <= 1'b0;
        end
    end

    // ==============================
    // beat transfer
    // ==============================

    assign sel_out   = lane_out[grant_idx];
    // one beat per cycle, only with room downstream
    assign beat_move = locked && sel_out.valid && !out_full;

    always_comb begin
        lane_pop = '0;
        if (beat_move) begin
            lane_pop[grant_idx] = 1'b1;
        end
    end

    sync_fifo #(
        .DEPTH  (OUT_FIFO_DEPTH),
        .item_t (upload_beat_t)
    ) u_out_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (beat_move),
        .push_item (sel_out.beat),
        .pop       (usb_pop),
        .head      (out_head),
        .empty     (out_empty),
        .full      (out_full),
        .count     ()
    );

    // head stays put while usb side stalls
    assign usb_upload_valid = !out_empty;
    assign usb_upload_data  = out_head.data;
    assign usb_pop          = usb_upload_valid && usb_upload_ready;

endmodule

// File: hw/frame_packer.sv
`timescale 1ns/1ps

module frame_packer import upload_pkg::*; #(
    parameter int         MAX_FRAME_DATA = 16,
    parameter source_id_t SOURCE_ID      = 8'h01
) (
    input  logic      clk,
    input  logic      rst_n,
    input  lane_in_t  lane_in,
    output logic      in_ready,
    output lane_out_t lane_out,
    input  logic      lane_pop
);

    localparam int CNT_W = $clog2(MAX_FRAME_DATA + 1);

    // collect, then walk the frame fields one pop at a time
    typedef enum logic [2:0] {
        ST_COLLECT,
        ST_HDR_H,
        ST_HDR_L,
        ST_SRC,
        ST_LEN,
        ST_DATA,
        ST_CSUM
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    byte_t            data_sum;
    byte_t            checksum;
    logic             collecting;
    logic             push;
    logic             fifo_pop;
    byte_t            fifo_head;
    logic             fifo_empty;
    logic [CNT_W-1:0] fifo_count;
    logic             close;

    // ==============================
    // burst collection
    // ==============================

    assign collecting = (state == ST_COLLECT);
    assign push       = collecting && lane_in.valid;
    assign count_next = count + CNT_W'(push);

    // count stays put as frame length through emission
    // full buffer closes too, burst goes on in a new frame
    assign close = collecting &&
                   ((lane_in.burst_end && (count_next != '0)) ||
                    (count_next == CNT_W'(MAX_FRAME_DATA)));

    // byte in flight from ingress counted too
    // closed while burst end is seen so a new burst waits
    assign in_ready = collecting && !lane_in.burst_end &&
                      (count_next < CNT_W'(MAX_FRAME_DATA));

    assign fifo_pop = (state == ST_DATA) && lane_pop;
    assign checksum = SOURCE_ID + byte_t'(count) + data_sum;

    sync_fifo #(
        .DEPTH  (MAX_FRAME_DATA),
        .item_t (byte_t)
    ) u_data_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_item (lane_in.data),
        .pop       (fifo_pop),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .full      (),
        .count     (fifo_count)
    );

    // ==============================
    // frame walk
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_COLLECT;
            count    <= '0;
            data_sum <= '0;
        end else begin
            case (state)
                ST_COLLECT: begin
                    count <= count_next;
                    if (push) begin
                        data_sum <= data_sum + lane_in.data;
                    end
                    if (close) begin
                        state <= ST_HDR_H;
                    end
                end
                ST_HDR_H: if (lane_pop) state <= ST_HDR_L;
                ST_HDR_L: if (lane_pop) state <= ST_SRC;
                ST_SRC:   if (lane_pop) state <= ST_LEN;
                ST_LEN:   if (lane_pop) state <= ST_DATA;
                // leave on the last buffered byte
                ST_DATA:  if (lane_pop && fifo_count == CNT_W'(1)) state <= ST_CSUM;
                ST_CSUM: begin
                    if (lane_pop) begin
                        state    <= ST_COLLECT;
                        count    <= '0;
                        data_sum <= '0;
                    end
                end
                default: state <= ST_COLLECT;
            endcase
        end
    end

    // output beat for the current field
    always_comb begin
        lane_out.frame_ready = !collecting;
        lane_out.valid       = !collecting;
        lane_out.beat.last   = (state == ST_CSUM);
        case (state)
            ST_HDR_H: lane_out.beat.data = FRAME_HEADER_H;
            ST_HDR_L: lane_out.beat.data = FRAME_HEADER_L;
            ST_SRC:   lane_out.beat.data = SOURCE_ID;
            ST_LEN:   lane_out.beat.data = byte_t'(count);
            ST_DATA: begin
                lane_out.beat.data = fifo_head;
                lane_out.valid     = !fifo_empty;
            end
            ST_CSUM:  lane_out.beat.data = checksum;
            default:  lane_out.beat.data = '0;
        endcase
    end

endmodule

// File: hw/upload_ingress.sv
`timescale 1ns/1ps

module upload_ingress import upload_pkg::*; #(
    parameter int NUM_LANES = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  src_in_t  src     [NUM_LANES],
    output lane_in_t lane_in [NUM_LANES]
);

    // ==============================
    // per-channel registers
    // ==============================

    // previous active level, for falling-edge detect
    logic [NUM_LANES-1:0] active_q;
    logic [NUM_LANES-1:0] valid_q;
    logic [NUM_LANES-1:0] end_q;
    byte_t                data_q [NUM_LANES];

    // control bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= '0;
            valid_q  <= '0;
            end_q    <= '0;
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                active_q[i] <= src[i].active;
                valid_q[i]  <= src[i].valid;
                // high one cycle after active dropped
                end_q[i]    <= active_q[i] & ~src[i].active;
            end
        end
    end

    // payload byte, only meaningful with valid
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            data_q[i] <= src[i].data;
        end
    end

    // ==============================
    // repack toward packers
    // ==============================

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_in[i].valid     = valid_q[i];
            lane_in[i].data      = data_q[i];
            lane_in[i].burst_end = end_q[i];
        end
    end

endmodule

// File: hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int  DEPTH  = 4,
    parameter type item_t = logic [7:0]
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         push,
    input  item_t                        push_item,
    input  logic                         pop,
    output item_t                        head,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(DEPTH+1)-1:0]   count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr];

    // storage, no reset needed
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // pointers wrap at DEPTH, not at a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

// File: hw/upload_pkg.sv
package upload_pkg;

    // ==============================
    // sizes
    // ==============================

    // upload channels merged toward usb
    localparam int NUM_LANES = 4;
    // data bytes per frame, also packer buffer depth
    localparam int MAX_FRAME_DATA = 16;
    // beats buffered ahead of the usb side
    localparam int OUT_FIFO_DEPTH = 4;

    // ==============================
    // basic types
    // ==============================

    typedef logic [7:0] byte_t;
    typedef logic [7:0] source_id_t;

    // frame sync bytes
    localparam byte_t FRAME_HEADER_H = 8'hAA;
    localparam byte_t FRAME_HEADER_L = 8'h44;

    // source code per lane, picked by generate index
    localparam source_id_t lane_source_ids [NUM_LANES] = '{8'h01, 8'h02, 8'h03, 8'h04};

    // ==============================
    // bundles
    // ==============================

    // what one channel drives
    typedef struct packed {
        logic  active;
        logic  valid;
        byte_t data;
    } src_in_t;

    // registered channel view, burst end as a pulse
    typedef struct packed {
        logic  valid;
        byte_t data;
        logic  burst_end;
    } lane_in_t;

    // one frame byte, last marks the checksum
    typedef struct packed {
        byte_t data;
        logic  last;
    } upload_beat_t;

    // packer toward arbiter
    typedef struct packed {
        logic         frame_ready;
        logic         valid;
        upload_beat_t beat;
    } lane_out_t;

endpackage
